//--- vlog.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/stage_reg.sv
src/fetch_unit.sv
src/decode_stage.sv
src/regfile.sv
src/exm_stage.sv
src/mem_arbiter.sv
src/pipeline_cpu.sv
testbench/cpu_assertions.sv
testbench/tb_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Compile with Verilator and run; pass only when the pass message appears

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing -f vlog.f --top-module tb_top \
    -Mdir obj_dir -o tb_top_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

out=$(./obj_dir/tb_top_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "STATUS: PASS"; then
    exit 0
fi
exit 1

//--- testbench/tb_top.sv
`timescale 1ns/1ps

module tb_top
    import isa_pkg::*;
();

    localparam int reset_cycles = 10;
    localparam int prog_len     = 16;    // 12 real words, then zero words
    localparam int mem_words    = 128;
    localparam int zero_limit   = 64;    // Zero words up to the data region
    localparam int st_idx       = 7;     // Word index of the SW
    localparam int timeout_cycles = reset_cycles + prog_len * 4 * 5 * 2 + 2 * 32;

    logic                 clk;
    logic                 resetn;
    logic                 mem_req;
    logic                 mem_we;
    logic [xlen_w-1:0]    mem_addr;
    logic [xlen_w-1:0]    mem_wdata;
    logic                 mem_ack;
    logic [xlen_w-1:0]    mem_rdata;
    logic [reg_idx_w-1:0] rf_addr;
    logic [xlen_w-1:0]    rf_data;
    logic                 retire_valid;
    logic [xlen_w-1:0]    retire_pc;
    logic [xlen_w-1:0]    retire_data;
    logic                 retire_wen;
    logic [reg_idx_w-1:0] retire_dest;

    logic [31:0] prog [0:prog_len-1];
    logic [31:0] mem  [0:mem_words-1];    // Memory model contents
    logic [31:0] smem [0:mem_words-1];    // Shadow copy, updated at retirement
    logic [31:0] sreg [0:31];             // Shadow register file
    logic [31:0] rng = 32'h6be5;
    logic [31:0] exp_pc = '0;
    logic [31:0] rd_q;
    logic        busy = 1'b0;
    int          wait_cnt = 0;
    int          retired = 0;
    int          stores = 0;
    int          errors = 0;

    pipeline_cpu dut0 (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] encode_itype(input logic [5:0] op, input int rs,
                                                 input int rt, input logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    function automatic logic [31:0] encode_addu(input int rs, input int rt, input int rd);
        return {op_special, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn_addu};
    endfunction

    function automatic logic [31:0] sext(input logic [31:0] inst);
        return {{16{inst[15]}}, inst[15:0]};
    endfunction

    // ----------------------------------------
    // Memory model with random latency of 1 to 4
    // ----------------------------------------
    always @(negedge clk)
    begin
        mem_ack = 1'b0;
        if (busy)
        begin
            if (wait_cnt == 0)
            begin
                mem_ack   = 1'b1;
                mem_rdata = rd_q;
                busy      = 1'b0;
            end
            else
                wait_cnt--;
        end
        else if (resetn && mem_req)
        begin
            rng      = xorshift(rng);
            wait_cnt = int'(rng % 4);    // Ack 1..4 cycles after the strobe
            busy     = 1'b1;
            rd_q     = mem[mem_addr[8:2]];
            if (mem_we)
            begin
                stores++;
                assert (mem_addr == sreg[prog[st_idx][25:21]] + sext(prog[st_idx])
                        && mem_wdata == sreg[prog[st_idx][20:16]])
                else begin
                    errors++;
                    $display("MISMATCH at %0t: store %h to %h unexpected", $time,
                             mem_wdata, mem_addr);
                end
                mem[mem_addr[8:2]] = mem_wdata;
            end
        end
    end

    // ----------------------------------------
    // Shadow model at retirement
    // ----------------------------------------
    always @(negedge clk)
    begin
        logic [31:0] inst;
        logic [31:0] val;
        logic [31:0] addr;
        int          dest;
        logic        wr;
        if (resetn && retire_valid)
        begin
            inst = (retire_pc[31:2] < prog_len) ? prog[retire_pc[5:2]] : '0;
            wr   = 1'b0;
            val  = '0;
            dest = 0;
            addr = sreg[inst[25:21]] + sext(inst);
            assert (retire_pc == exp_pc)
            else begin
                errors++;
                $display("MISMATCH at %0t: retire_pc %h, expected %h", $time,
                         retire_pc, exp_pc);
            end
            if (inst[31:26] == op_special && inst[5:0] == fn_addu)
            begin
                val  = sreg[inst[25:21]] + sreg[inst[20:16]];
                dest = int'(inst[15:11]);
                wr   = 1'b1;
            end
            else if (inst[31:26] == op_addiu)
            begin
                val  = addr;
                dest = int'(inst[20:16]);
                wr   = 1'b1;
            end
            else if (inst[31:26] == op_lw)
            begin
                val  = smem[addr[8:2]];
                dest = int'(inst[20:16]);
                wr   = 1'b1;
            end
            else if (inst[31:26] == op_sw)
                smem[addr[8:2]] = sreg[inst[20:16]];
            if (dest == 0)
                wr = 1'b0;    // r0 stays zero
            assert (retire_wen == wr && (!wr || (int'(retire_dest) == dest
                    && retire_data == val)))
            else begin
                errors++;
                $display("MISMATCH at %0t: pc %h wen %b r%0d=%h, expected %b r%0d=%h",
                         $time, retire_pc, retire_wen, retire_dest, retire_data,
                         wr, dest, val);
            end
            if (wr)
                sreg[dest] = val;
            exp_pc = exp_pc + pc_step;
            retired++;
        end
    end

    // Watchdog
    initial
    begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timeout: program did not retire within %0d cycles", timeout_cycles);
        $display("STATUS: FAIL");
        $finish;
    end

    initial
    begin
        logic [31:0] a;
        clk     = 1'b0;
        resetn  = 1'b0;
        mem_ack = 1'b0;
        mem_rdata = '0;
        rf_addr = '0;
        // Program
        prog[0]  = encode_itype(op_addiu, 0, 1, 16'd5);
        prog[1]  = encode_itype(op_addiu, 1, 2, 16'd7);
        prog[2]  = encode_itype(op_addiu, 2, 3, 16'hfffd);   // -3
        prog[3]  = encode_addu(1, 2, 4);
        prog[4]  = encode_addu(4, 3, 5);                     // Back-to-back dependent
        prog[5]  = encode_addu(5, 5, 6);
        prog[6]  = encode_itype(op_addiu, 0, 7, 16'h0100);
        prog[7]  = encode_itype(op_sw, 7, 6, 16'h0000);
        prog[8]  = encode_itype(op_lw, 7, 8, 16'h0000);
        prog[9]  = encode_addu(8, 1, 9);                     // Uses the load
        prog[10] = encode_itype(op_addiu, 0, 0, 16'd99);
        prog[11] = encode_addu(9, 9, 0);
        for (int i = 12; i < prog_len; i++)
            prog[i] = '0;
        for (int i = 0; i < mem_words; i++)
        begin
            a = 32'(i) << 2;
            if (i < prog_len)
                mem[i] = prog[i];
            else if (i < zero_limit)
                mem[i] = '0;
            else
                mem[i] = {~a[15:0], a[15:0]};
            smem[i] = mem[i];
        end
        for (int r = 0; r < 32; r++)
            sreg[r] = '0;
        repeat (reset_cycles) @(negedge clk);
        resetn = 1'b1;
        wait (retired >= prog_len);
        // ----------------------------------------
        // Final register sweep
        // ----------------------------------------
        for (int r = 0; r < 32; r++)
        begin
            @(negedge clk);
            rf_addr = 5'(r);
            @(negedge clk);
            assert (rf_data == sreg[r])
            else begin
                errors++;
                $display("MISMATCH at %0t: r%0d reads %h, expected %h", $time, r,
                         rf_data, sreg[r]);
            end
        end
        if (stores != 1)
        begin
            errors++;
            $display("Store count wrong: saw %0d bus writes, expected one", stores);
        end
        $display("Errors: %0d testbench, %0d assertion", errors,
                 dut0.u_cpu_assertions.fail_count);
        if (errors == 0 && dut0.u_cpu_assertions.fail_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- testbench/cpu_assertions.sv
`timescale 1ns/1ps

module cpu_assertions
    import isa_pkg::*;
(
    input logic                 clk,
    input logic                 resetn,
    input logic                 mem_req,
    input logic [xlen_w-1:0]    mem_addr,
    input logic                 mem_ack,
    input logic                 retire_valid,
    input logic                 retire_wen,
    input logic [reg_idx_w-1:0] retire_dest
);

    int   fail_count = 0;    // Read by the testbench for the final tally
    logic busy_q;            // Bus access in flight, mem_req to mem_ack

    always_ff @(posedge clk)
    begin
        if (!resetn)
            busy_q <= 1'b0;
        else if (mem_req)
            busy_q <= 1'b1;
        else if (mem_ack)
            busy_q <= 1'b0;
    end

    // ----------------------------------------
    // Reset behavior
    // ----------------------------------------
    reset_quiet: assert property (@(posedge clk) !resetn |-> !mem_req && !retire_valid)
        else begin fail_count++; $error("Bus request or retirement during reset"); end

    first_cycle_quiet: assert property (@(posedge clk)
        $rose(resetn) |-> !mem_req && !retire_valid)
        else begin fail_count++; $error("Activity in first cycle after reset"); end

    // ----------------------------------------
    // Bus discipline
    // ----------------------------------------
    single_outstanding: assert property (@(posedge clk) disable iff (!resetn)
        mem_req |-> !busy_q)
        else begin fail_count++; $error("New request while one is outstanding"); end

    word_aligned: assert property (@(posedge clk) disable iff (!resetn)
        mem_req |-> mem_addr[1:0] == 2'b00)
        else begin fail_count++; $error("Unaligned bus address"); end

    // r0 is never a real destination
    no_r0_write: assert property (@(posedge clk) disable iff (!resetn)
        retire_wen |-> retire_dest != '0)
        else begin fail_count++; $error("Register 0 written at retirement"); end

endmodule

bind pipeline_cpu cpu_assertions u_cpu_assertions (
    .clk(clk), .resetn(resetn),
    .mem_req(mem_req), .mem_addr(mem_addr), .mem_ack(mem_ack),
    .retire_valid(retire_valid), .retire_wen(retire_wen), .retire_dest(retire_dest)
);

//--- src/pipeline_cpu.sv
`timescale 1ns/1ps

module pipeline_cpu
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    output logic                 mem_req,
    output logic                 mem_we,
    output logic [xlen_w-1:0]    mem_addr,
    output logic [xlen_w-1:0]    mem_wdata,
    input  logic                 mem_ack,
    input  logic [xlen_w-1:0]    mem_rdata,
    input  logic [reg_idx_w-1:0] rf_addr,
    output logic [xlen_w-1:0]    rf_data,
    output logic                 retire_valid,
    output logic [xlen_w-1:0]    retire_pc,
    output logic [xlen_w-1:0]    retire_data,
    output logic                 retire_wen,
    output logic [reg_idx_w-1:0] retire_dest
);

    // ----------------------------------------
    // Requester side of the bus
    // ----------------------------------------
    logic              fetch_req;
    logic [xlen_w-1:0] fetch_addr;
    logic              fetch_grant;
    logic              fetch_ack;
    logic              data_req;
    logic              data_we;
    logic [xlen_w-1:0] data_addr;
    logic [xlen_w-1:0] data_wdata;
    logic              data_grant;
    logic              data_ack;

    // ----------------------------------------
    // Stage slots, in and out
    // ----------------------------------------
    logic    if_valid;
    if_id_t  if_data;
    logic    if_ready;
    logic    id_valid;
    if_id_t  id_data;
    logic    id_ready;
    logic    id_exm_in_valid;
    id_exm_t id_exm_in_data;
    logic    id_exm_in_ready;
    logic    exm_valid;
    id_exm_t exm_data;
    logic    exm_ready;
    logic    wb_in_valid;
    exm_wb_t wb_in_data;
    logic    wb_in_ready;
    exm_wb_t wb_data;

    // Register file read side
    logic [reg_idx_w-1:0] rs_idx;
    logic [reg_idx_w-1:0] rt_idx;
    logic [xlen_w-1:0]    rs_value;
    logic [xlen_w-1:0]    rt_value;

    // Retire straight off the EXM/WB slot
    assign retire_pc   = wb_data.pc;
    assign retire_data = wb_data.result;
    assign retire_dest = wb_data.dest;
    assign retire_wen  = retire_valid && wb_data.wen;

    fetch_unit u_fetch (
        .clk(clk), .resetn(resetn),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .fetch_grant(fetch_grant), .fetch_ack(fetch_ack), .mem_rdata(mem_rdata),
        .if_valid(if_valid), .if_data(if_data), .if_ready(if_ready)
    );

    stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk(clk), .resetn(resetn),
        .in_valid(if_valid), .in_data(if_data), .in_ready(if_ready),
        .out_valid(id_valid), .out_data(id_data), .out_ready(id_ready)
    );

    decode_stage u_decode (
        .id_valid(id_valid), .id_data(id_data), .id_ready(id_ready),
        .rs_idx(rs_idx), .rt_idx(rt_idx), .rs_value(rs_value), .rt_value(rt_value),
        .exm_busy_valid(exm_valid && exm_data.wen), .exm_busy_dest(exm_data.dest),
        .wb_busy_valid(retire_wen), .wb_busy_dest(wb_data.dest),
        .exm_valid_in(id_exm_in_valid), .exm_in_data(id_exm_in_data),
        .exm_in_ready(id_exm_in_ready)
    );

    stage_reg #(.payload_t(id_exm_t)) u_id_exm (
        .clk(clk), .resetn(resetn),
        .in_valid(id_exm_in_valid), .in_data(id_exm_in_data), .in_ready(id_exm_in_ready),
        .out_valid(exm_valid), .out_data(exm_data), .out_ready(exm_ready)
    );

    exm_stage u_exm (
        .clk(clk), .resetn(resetn),
        .exm_valid(exm_valid), .exm_data(exm_data), .exm_ready(exm_ready),
        .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .data_grant(data_grant), .data_ack(data_ack), .mem_rdata(mem_rdata),
        .wb_valid_in(wb_in_valid), .wb_in_data(wb_in_data), .wb_in_ready(wb_in_ready)
    );

    // WB always drains
    stage_reg #(.payload_t(exm_wb_t)) u_exm_wb (
        .clk(clk), .resetn(resetn),
        .in_valid(wb_in_valid), .in_data(wb_in_data), .in_ready(wb_in_ready),
        .out_valid(retire_valid), .out_data(wb_data), .out_ready(1'b1)
    );

    regfile u_rf (
        .clk(clk),
        .wen(retire_wen), .waddr(retire_dest), .wdata(retire_data),
        .raddr1(rs_idx), .raddr2(rt_idx), .rdata1(rs_value), .rdata2(rt_value),
        .dbg_addr(rf_addr), .dbg_data(rf_data)
    );

    mem_arbiter u_arb (
        .clk(clk), .resetn(resetn),
        .fetch_req(fetch_req), .fetch_addr(fetch_addr),
        .data_req(data_req), .data_we(data_we),
        .data_addr(data_addr), .data_wdata(data_wdata),
        .fetch_grant(fetch_grant), .data_grant(data_grant),
        .fetch_ack(fetch_ack), .data_ack(data_ack),
        .mem_req(mem_req), .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata),
        .mem_ack(mem_ack)
    );

endmodule

//--- src/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              fetch_req,
    input  logic [xlen_w-1:0] fetch_addr,
    input  logic              data_req,
    input  logic              data_we,
    input  logic [xlen_w-1:0] data_addr,
    input  logic [xlen_w-1:0] data_wdata,
    output logic              fetch_grant,
    output logic              data_grant,
    output logic              fetch_ack,
    output logic              data_ack,
    output logic              mem_req,
    output logic              mem_we,
    output logic [xlen_w-1:0] mem_addr,
    output logic [xlen_w-1:0] mem_wdata,
    input  logic              mem_ack
);

    logic       outstanding_q;   // From mem_req to mem_ack
    req_owner_t owner_q;

    // Fixed priority, data first
    assign data_grant  = !outstanding_q && data_req;
    assign fetch_grant = !outstanding_q && fetch_req && !data_req;

    // Grant cycle is the request strobe
    assign mem_req   = data_grant || fetch_grant;
    assign mem_we    = data_grant && data_we;
    assign mem_addr  = data_grant ? data_addr : fetch_addr;
    assign mem_wdata = data_wdata;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            outstanding_q <= 1'b0;
        else if (mem_req)
            outstanding_q <= 1'b1;
        else if (mem_ack)
            outstanding_q <= 1'b0;
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
            owner_q <= owner_fetch;
        else if (mem_req)
            owner_q <= data_grant ? owner_data : owner_fetch;
    end

    // Route the ack back to whoever asked
    assign fetch_ack = mem_ack && outstanding_q && (owner_q == owner_fetch);
    assign data_ack  = mem_ack && outstanding_q && (owner_q == owner_data);

endmodule

//--- src/exm_stage.sv
`timescale 1ns/1ps

module exm_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    input  logic              exm_valid,
    input  id_exm_t           exm_data,
    output logic              exm_ready,
    output logic              data_req,
    output logic              data_we,
    output logic [xlen_w-1:0] data_addr,
    output logic [xlen_w-1:0] data_wdata,
    input  logic              data_grant,
    input  logic              data_ack,
    input  logic [xlen_w-1:0] mem_rdata,
    output logic              wb_valid_in,
    output exm_wb_t           wb_in_data,
    input  logic              wb_in_ready
);

    logic [xlen_w-1:0] sum;
    logic              is_mem;
    logic              done;
    logic              issued_q;    // Bus access granted, waiting for ack

    assign sum    = exm_data.op_a + exm_data.op_b;   // ALU result or address
    assign is_mem = (exm_data.kind == kind_load) || (exm_data.kind == kind_store);
    assign done   = !is_mem || data_ack;

    // ----------------------------------------
    // Single data access per load/store
    // ----------------------------------------
    assign data_req   = exm_valid && is_mem && !issued_q;
    assign data_we    = (exm_data.kind == kind_store);
    assign data_addr  = sum;
    assign data_wdata = exm_data.store_data;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            issued_q <= 1'b0;
        else if (data_grant)
            issued_q <= 1'b1;
        else if (data_ack)
            issued_q <= 1'b0;
    end

    assign exm_ready   = done && wb_in_ready;
    assign wb_valid_in = exm_valid && done;

    assign wb_in_data.pc     = exm_data.pc;
    assign wb_in_data.wen    = exm_data.wen;
    assign wb_in_data.dest   = exm_data.dest;
    assign wb_in_data.result = (exm_data.kind == kind_load) ? mem_rdata : sum;

endmodule

//--- src/regfile.sv
`timescale 1ns/1ps

module regfile
    import isa_pkg::*;
(
    input  logic                 clk,
    input  logic                 wen,
    input  logic [reg_idx_w-1:0] waddr,
    input  logic [xlen_w-1:0]    wdata,
    input  logic [reg_idx_w-1:0] raddr1,
    input  logic [reg_idx_w-1:0] raddr2,
    output logic [xlen_w-1:0]    rdata1,
    output logic [xlen_w-1:0]    rdata2,
    input  logic [reg_idx_w-1:0] dbg_addr,    // Debug read port
    output logic [xlen_w-1:0]    dbg_data
);

    logic [xlen_w-1:0] regs [0:(1<<reg_idx_w)-1];

    always_ff @(posedge clk)
    begin
        if (wen && waddr != '0)
            regs[waddr] <= wdata;
    end

    // Combinational reads, r0 hardwired to zero
    assign rdata1   = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2   = (raddr2 == '0) ? '0 : regs[raddr2];
    assign dbg_data = (dbg_addr == '0) ? '0 : regs[dbg_addr];

endmodule

//--- src/decode_stage.sv
`timescale 1ns/1ps

module decode_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic                 id_valid,
    input  if_id_t               id_data,
    output logic                 id_ready,
    output logic [reg_idx_w-1:0] rs_idx,
    output logic [reg_idx_w-1:0] rt_idx,
    input  logic [xlen_w-1:0]    rs_value,
    input  logic [xlen_w-1:0]    rt_value,
    input  logic                 exm_busy_valid,   // EXM holds a writer
    input  logic [reg_idx_w-1:0] exm_busy_dest,
    input  logic                 wb_busy_valid,    // WB holds a writer
    input  logic [reg_idx_w-1:0] wb_busy_dest,
    output logic                 exm_valid_in,
    output id_exm_t              exm_in_data,
    input  logic                 exm_in_ready
);

    logic [op_w-1:0]      opcode;
    logic [fn_w-1:0]      funct;
    logic [reg_idx_w-1:0] rd_idx;
    logic [imm_w-1:0]     imm;
    logic                 is_addu;
    logic                 is_addiu;
    logic                 is_lw;
    logic                 is_sw;
    logic                 uses_rs;
    logic                 uses_rt;
    logic                 exm_hit;
    logic                 wb_hit;
    logic                 stall;

    // ----------------------------------------
    // Field extraction
    // ----------------------------------------
    assign opcode = id_data.inst[op_lsb +: op_w];
    assign funct  = id_data.inst[fn_w-1:0];
    assign rs_idx = id_data.inst[rs_lsb +: reg_idx_w];
    assign rt_idx = id_data.inst[rt_lsb +: reg_idx_w];
    assign rd_idx = id_data.inst[rd_lsb +: reg_idx_w];
    assign imm    = id_data.inst[imm_w-1:0];

    assign is_addu  = (opcode == op_special) && (funct == fn_addu);
    assign is_addiu = (opcode == op_addiu);
    assign is_lw    = (opcode == op_lw);
    assign is_sw    = (opcode == op_sw);
    assign uses_rs  = is_addu || is_addiu || is_lw || is_sw;
    assign uses_rt  = is_addu || is_sw;    // rt is a source only here

    // RAW interlock against older writers, r0 never conflicts
    assign exm_hit = exm_busy_valid && (exm_busy_dest != '0)
                     && ((uses_rs && exm_busy_dest == rs_idx)
                         || (uses_rt && exm_busy_dest == rt_idx));
    assign wb_hit  = wb_busy_valid && (wb_busy_dest != '0)
                     && ((uses_rs && wb_busy_dest == rs_idx)
                         || (uses_rt && wb_busy_dest == rt_idx));
    assign stall   = exm_hit || wb_hit;

    assign exm_valid_in = id_valid && !stall;
    assign id_ready     = exm_in_ready && !stall;

    // ----------------------------------------
    // Payload towards EXM
    // ----------------------------------------
    always_comb
    begin
        exm_in_data.pc         = id_data.pc;
        exm_in_data.op_a       = rs_value;
        exm_in_data.op_b       = is_addu ? rt_value
                                         : {{(xlen_w-imm_w){imm[imm_w-1]}}, imm};
        exm_in_data.store_data = rt_value;
        exm_in_data.dest       = is_addu ? rd_idx : rt_idx;
        exm_in_data.wen        = (is_addu || is_addiu || is_lw)
                                 && (exm_in_data.dest != '0);  // Drop r0 writes
        if (is_addu || is_addiu)
            exm_in_data.kind = kind_alu;
        else if (is_lw)
            exm_in_data.kind = kind_load;
        else if (is_sw)
            exm_in_data.kind = kind_store;
        else
            exm_in_data.kind = kind_none;    // Bubble, no write
    end

endmodule

//--- src/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic              clk,
    input  logic              resetn,
    output logic              fetch_req,
    output logic [xlen_w-1:0] fetch_addr,
    input  logic              fetch_grant,
    input  logic              fetch_ack,
    input  logic [xlen_w-1:0] mem_rdata,
    output logic              if_valid,
    output if_id_t            if_data,
    input  logic              if_ready
);

    logic              run_q;         // Up one cycle after reset release
    logic [xlen_w-1:0] pc_q;
    logic              pending_q;     // Granted, waiting for ack
    logic              buf_valid_q;   // One-entry instruction buffer
    logic [xlen_w-1:0] buf_inst_q;

    // Next word only once the buffer is empty
    assign fetch_req    = run_q && !pending_q && !buf_valid_q;
    assign fetch_addr   = pc_q;
    assign if_valid     = buf_valid_q;
    assign if_data.pc   = pc_q;
    assign if_data.inst = buf_inst_q;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            run_q       <= 1'b0;
            pc_q        <= '0;
            pending_q   <= 1'b0;
            buf_valid_q <= 1'b0;
        end
        else
        begin
            run_q <= 1'b1;
            if (fetch_grant)
                pending_q <= 1'b1;
            else if (fetch_ack)
                pending_q <= 1'b0;
            if (fetch_ack)
                buf_valid_q <= 1'b1;
            else if (if_valid && if_ready)
            begin
                buf_valid_q <= 1'b0;
                pc_q        <= pc_q + pc_step;   // Advance on IF/ID accept
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (fetch_ack)
            buf_inst_q <= mem_rdata;
    end

endmodule

//--- src/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     resetn,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,    // Allow-in towards the older stage
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     valid_q;
    payload_t data_q;

    // Empty, or the current occupant leaves this cycle
    assign in_ready = !valid_q || out_ready;

    always_ff @(posedge clk)
    begin
        if (!resetn)
            valid_q <= 1'b0;
        else if (in_ready)
            valid_q <= in_valid;    // Load new, or go empty after drain
    end

    // Payload only
    always_ff @(posedge clk)
    begin
        if (in_valid && in_ready)
            data_q <= in_data;
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;

endmodule

//--- src/pipe_pkg.sv
package pipe_pkg;

    import isa_pkg::*;

    // Instruction class carried down the pipe
    typedef enum logic [1:0] {
        kind_none,     // Bubble or unsupported encoding
        kind_alu,
        kind_load,
        kind_store
    } kind_t;

    // Who owns the outstanding bus access
    typedef enum logic {
        owner_fetch,
        owner_data
    } req_owner_t;

    // ----------------------------------------
    // Stage payloads
    // ----------------------------------------
    typedef struct packed {
        logic [xlen_w-1:0] pc;
        logic [xlen_w-1:0] inst;
    } if_id_t;                          // 64 bits

    typedef struct packed {
        logic [xlen_w-1:0]    pc;
        kind_t                kind;
        logic [xlen_w-1:0]    op_a;         // rs value
        logic [xlen_w-1:0]    op_b;         // rt value or sign-extended imm
        logic [xlen_w-1:0]    store_data;
        logic [reg_idx_w-1:0] dest;
        logic                 wen;          // Never set for r0
    } id_exm_t;                         // 136 bits

    typedef struct packed {
        logic [xlen_w-1:0]    pc;
        logic                 wen;
        logic [reg_idx_w-1:0] dest;
        logic [xlen_w-1:0]    result;
    } exm_wb_t;                         // 70 bits

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    // ----------------------------------------
    // Widths
    // ----------------------------------------
    localparam int xlen_w    = 32;    // Data and address
    localparam int reg_idx_w = 5;     // 32 GPRs
    localparam int op_w      = 6;     // Primary opcode
    localparam int fn_w      = 6;     // SPECIAL function code
    localparam int imm_w     = 16;

    // Field positions in the instruction word
    localparam int op_lsb = 26;
    localparam int rs_lsb = 21;
    localparam int rt_lsb = 16;
    localparam int rd_lsb = 11;

    // ----------------------------------------
    // Encodings of the supported subset
    // ----------------------------------------
    localparam logic [op_w-1:0] op_special = 6'h00;
    localparam logic [op_w-1:0] op_addiu   = 6'h09;
    localparam logic [op_w-1:0] op_lw      = 6'h23;
    localparam logic [op_w-1:0] op_sw      = 6'h2b;
    localparam logic [fn_w-1:0] fn_addu    = 6'h21;

    localparam logic [xlen_w-1:0] pc_step = 32'd4;   // Word-sized instructions

endpackage
